// File: Bender.yml
package:
  name: mem_arbiter

sources:
  - include_dirs:
      - include
    files:
      - verilog/arbiter_pkg.sv
      - verilog/arbiter_fsm.sv
      - verilog/beat_counter.sv
      - verilog/request_mux.sv
      - verilog/response_router.sv
      - verilog/mem_arbiter.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/mem_model.sv
      - tb/mem_arbiter_tb.sv

// File: include/arbiter_defs.svh
// Sizing for the cache-to-bus arbiter; only eight-beat read bursts are supported.
`ifndef ARBITER_DEFS_SVH
`define ARBITER_DEFS_SVH

// Width of one request word and of one response beat.
`define ARB_DATA_W 64

// Transaction tag width, carried unchanged from request to response.
`define ARB_TAG_W 13

// Beats per transfer.
// The response router and the memory side both assume this fixed length.
`define ARB_BURST_LEN 8

// Each cache sees its resp field at all ones whenever no beat is delivered,
// and that pattern matches the all ones that the bus returns on an idle data path.
// Widths above must match what the caches and the system bus were built with.

`endif

// File: mem_arbiter.f
+incdir+include
verilog/arbiter_pkg.sv
verilog/arbiter_fsm.sv
verilog/beat_counter.sv
verilog/request_mux.sv
verilog/response_router.sv
verilog/mem_arbiter.sv
tb/mem_model.sv
tb/mem_arbiter_tb.sv

// File: tb/mem_arbiter_tb.sv
// Testbench for mem_arbiter; 20 random requests per cache, fixed seed, stops at the first error.
`timescale 1ns/100ps

`include "arbiter_defs.svh"

module mem_arbiter_tb import arbiter_pkg::*; ();

	localparam int PERIOD    = 8;
	localparam int PER_CACHE = 20; // 40 transfers in all.
	localparam int MAX_WAIT  = 4;
	localparam int MAX_GAP   = 3;
	localparam int MAX_IDLE  = 3;  // Cache pause between its requests.
	localparam int XFER_CYC  = MAX_IDLE + MAX_WAIT + `ARB_BURST_LEN * (MAX_GAP + 1) + 8;
	localparam int LIMIT_NS  = (2 * PER_CACHE * XFER_CYC + 50) * PERIOD;
	localparam logic [31:0] SEED = 32'hd7f8;
	localparam logic [`ARB_DATA_W-1:0] ONES = '1;

	logic        bus = 1'b0;
	logic        rst_n;
	cache_req_t  icache_req;
	cache_req_t  dcache_req;
	logic        icache_reqack;
	logic        dcache_reqack;
	cache_resp_t icache_resp;
	cache_resp_t dcache_resp;
	bus_req_t    mem_req;
	logic        mem_reqack;
	logic        mem_respack;
	bus_resp_t   mem_resp;

	integer                 seed;
	logic [`ARB_DATA_W-1:0] word_tab [2][PER_CACHE]; // Issued requests, 0 icache, 1 dcache.
	logic [`ARB_TAG_W-1:0]  tag_tab  [2][PER_CACHE];
	int                     ack_idx  [2];
	int                     done_idx [2];
	int                     owner;   // -1 with no transfer in flight.
	int                     beats;   // Beats seen in the current burst.
	bus_resp_t              p_mem_resp; // Values one cycle back.
	logic                   p_mem_reqack;
	logic                   pp_mem_reqack; // Two cycles back.
	logic                   p_mem_reqcyc;
	logic                   p_icache_reqcyc;
	logic                   p_ack;
	logic [1:0]             p_respcyc;

	mem_arbiter dut (
		.bus(bus), .rst_n(rst_n),
		.icache_req(icache_req), .dcache_req(dcache_req),
		.mem_reqack(mem_reqack), .mem_resp(mem_resp),
		.icache_reqack(icache_reqack), .dcache_reqack(dcache_reqack),
		.icache_resp(icache_resp), .dcache_resp(dcache_resp),
		.mem_req(mem_req), .mem_respack(mem_respack)
	);

	mem_model #(.MAX_WAIT(MAX_WAIT), .MAX_GAP(MAX_GAP), .SEED(SEED)) memory (
		.bus(bus), .rst_n(rst_n), .mem_req(mem_req), .mem_respack(mem_respack),
		.mem_reqack(mem_reqack), .mem_resp(mem_resp)
	);

	always #(PERIOD / 2) bus = ~bus;

	task automatic stop_fail();
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic bad_value(input string name, input logic [`ARB_DATA_W-1:0] got,
		input logic [`ARB_DATA_W-1:0] exp);
		$display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		stop_fail();
	endtask

	task automatic bad_event(input string what);
		$display("Error: %s at %0t", what, $time);
		stop_fail();
	endtask

	function automatic int draw(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[30:0] % (n + 1));
	endfunction

	task automatic step();
		@(posedge bus);
		#1; // Inputs change just after the edge.
	endtask

	function automatic cache_resp_t resp_of(input int c);
		return (c == 0) ? icache_resp : dcache_resp;
	endfunction

	task automatic set_req(input int c, input cache_req_t r);
		if (c == 0) icache_req = r;
		else dcache_req = r;
	endtask

	// One cache: raise, hold until reqack, pause, repeat.
	task automatic drive_cache(input int c);
		cache_req_t r;
		for (int n = 0; n < PER_CACHE; n++) begin
			r.reqcyc = 1'b1;
			r.req    = `ARB_DATA_W'({$random(seed), $random(seed)});
			r.reqtag = `ARB_TAG_W'($random(seed));
			word_tab[c][n] = r.req;
			tag_tab[c][n]  = r.reqtag;
			set_req(c, r);
			@(negedge bus);
			while (!(c == 0 ? icache_reqack : dcache_reqack)) @(negedge bus);
			step();
			set_req(c, '0);
			repeat (draw(MAX_IDLE)) step();
		end
	endtask

	initial begin
		seed       = SEED;
		rst_n      = 1'b0;
		icache_req = '0;
		dcache_req = '0;
		owner      = -1;
		beats      = 0;
		ack_idx    = '{0, 0};
		done_idx   = '{0, 0};
		repeat (4) @(posedge bus);
		#1;
		rst_n = 1'b1;
		fork // Both caches start in the same idle cycle.
			drive_cache(0);
			drive_cache(1);
		join
		wait (done_idx[0] == PER_CACHE && done_idx[1] == PER_CACHE);
		repeat (2) @(negedge bus);
		if (ack_idx[0] == PER_CACHE && ack_idx[1] == PER_CACHE &&
			owner == -1 && !mem_req.reqcyc) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			bad_event("request count or bus state wrong at end of run");
		end
	end

	// Watchdog over all transfers.
	initial begin
		#(LIMIT_NS);
		bad_event("timeout, transfers did not finish");
	end

	// Checks at the falling edge, where all signals are settled.
	always @(negedge bus) begin
		int                     c;
		cache_resp_t            o;
		cache_resp_t            q;
		string                  nm;
		logic [`ARB_DATA_W-1:0] exp_word;
		logic                   exp_respack;
		if (!rst_n) begin
			assert (!mem_req.reqcyc) else bad_value("mem_req.reqcyc", mem_req.reqcyc, 0);
			assert (!icache_reqack && !dcache_reqack) else bad_event("reqack high in reset");
			assert (!icache_resp.respcyc && !dcache_resp.respcyc)
				else bad_event("respcyc high in reset");
			assert (!mem_respack) else bad_value("mem_respack", mem_respack, 0);
			assert (icache_resp.resp == ONES)
				else bad_value("icache_resp.resp", icache_resp.resp, ONES);
			assert (dcache_resp.resp == ONES)
				else bad_value("dcache_resp.resp", dcache_resp.resp, ONES);
		end else begin
			assert (!(icache_reqack && dcache_reqack)) else bad_event("both reqacks high");
			if (icache_reqack || dcache_reqack) begin
				c = icache_reqack ? 0 : 1;
				assert (!p_ack) else bad_event("reqack longer than one cycle");
				assert (owner == -1) else bad_event("reqack during a burst");
				assert (c == 0 || !p_icache_reqcyc)
					else bad_event("dcache won over a waiting icache");
				assert (ack_idx[c] < PER_CACHE) else bad_event("reqack with nothing pending");
				assert (mem_req.reqcyc) else bad_value("mem_req.reqcyc", mem_req.reqcyc, 1);
				assert (mem_req.req == word_tab[c][ack_idx[c]])
					else bad_value("mem_req.req", mem_req.req, word_tab[c][ack_idx[c]]);
				assert (mem_req.reqtag == tag_tab[c][ack_idx[c]])
					else bad_value("mem_req.reqtag", mem_req.reqtag, tag_tab[c][ack_idx[c]]);
				owner      = c;
				beats      = 0;
				ack_idx[c] = ack_idx[c] + 1;
			end
			// Strobe stays up for the cycle after the ack is sampled, then drops.
			assert (!p_mem_reqack || mem_req.reqcyc)
				else bad_value("mem_req.reqcyc", mem_req.reqcyc, 1);
			assert (!pp_mem_reqack || !mem_req.reqcyc)
				else bad_value("mem_req.reqcyc", mem_req.reqcyc, 0);
			assert (!p_mem_reqcyc || mem_req.reqcyc || pp_mem_reqack)
				else bad_event("mem_req.reqcyc fell before mem_reqack was sampled");
			if (owner != -1) o = resp_of(owner);
			nm = (owner == 0) ? "icache_resp" : "dcache_resp";
			if (p_mem_resp.respcyc) begin
				assert (owner != -1) else bad_event("bus beat with no transfer");
				exp_word = word_tab[owner][done_idx[owner]] + beats;
				assert (o.respcyc) else bad_value({nm, ".respcyc"}, o.respcyc, 1);
				assert (o.resp == p_mem_resp.resp)
					else bad_value({nm, ".resp"}, o.resp, p_mem_resp.resp);
				assert (o.resptag == p_mem_resp.resptag)
					else bad_value({nm, ".resptag"}, o.resptag, p_mem_resp.resptag);
				assert (o.resp == exp_word) else bad_value({nm, ".resp"}, o.resp, exp_word);
				assert (o.resptag == tag_tab[owner][done_idx[owner]])
					else bad_value({nm, ".resptag"}, o.resptag, tag_tab[owner][done_idx[owner]]);
				beats = beats + 1;
				assert (beats <= `ARB_BURST_LEN) else bad_event("too many beats in one burst");
			end else begin
				assert (icache_resp.resp == ONES)
					else bad_value("icache_resp.resp", icache_resp.resp, ONES);
				assert (dcache_resp.resp == ONES)
					else bad_value("dcache_resp.resp", dcache_resp.resp, ONES);
			end
			// Owner's respcyc falling closes the transfer.
			if (owner != -1 && p_respcyc[owner] && !o.respcyc) begin
				assert (beats == `ARB_BURST_LEN)
					else bad_value("beats per burst", beats, `ARB_BURST_LEN);
				done_idx[owner] = done_idx[owner] + 1;
				owner = -1;
			end
			for (int k = 0; k < 2; k++) begin
				q = resp_of(k);
				if (k != owner) begin
					assert (!q.respcyc) else bad_value("non-owner respcyc", q.respcyc, 0);
					assert (q.resp == ONES) else bad_value("non-owner resp", q.resp, ONES);
				end
			end
			// Level from the first delivered beat to the end of the burst.
			exp_respack = (owner != -1) && (beats > 0);
			assert (mem_respack == exp_respack)
				else bad_value("mem_respack", mem_respack, exp_respack);
		end
		pp_mem_reqack   = p_mem_reqack;
		p_mem_resp      = mem_resp;
		p_mem_reqack    = mem_reqack;
		p_mem_reqcyc    = mem_req.reqcyc;
		p_icache_reqcyc = icache_req.reqcyc;
		p_ack           = icache_reqack | dcache_reqack;
		p_respcyc       = {dcache_resp.respcyc, icache_resp.respcyc};
	end

endmodule

// File: tb/mem_model.sv
// Simulation-only bus memory; serves one request at a time and answers with a fixed-length burst.
`timescale 1ns/100ps

`include "arbiter_defs.svh"

module mem_model import arbiter_pkg::*; #(
	parameter int MAX_WAIT = 4, // Longest delay before mem_reqack, in cycles.
	parameter int MAX_GAP  = 3, // Longest idle gap before a beat.
	parameter int SEED     = 1
) (
	input  logic      bus,
	input  logic      rst_n,
	input  bus_req_t  mem_req,
	input  logic      mem_respack,
	output logic      mem_reqack,
	output bus_resp_t mem_resp
);

	localparam bus_resp_t IDLE = '{respcyc: 1'b0, resp: '1, resptag: '0};

	integer                 seed;
	logic [`ARB_DATA_W-1:0] word; // Captured request word.
	logic [`ARB_TAG_W-1:0]  tag;

	// Uniform draw in 0..n.
	function automatic int draw(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[30:0] % (n + 1));
	endfunction

	// Move to just after the next rising edge.
	task automatic step();
		@(posedge bus);
		#1;
	endtask

	initial begin
		seed       = SEED;
		mem_reqack = 1'b0;
		mem_resp   = IDLE; // Idle bus data reads all ones.
		forever begin
			@(negedge bus);
			if (rst_n && mem_req.reqcyc) begin
				word = mem_req.req; // Held by the arbiter until acked.
				tag  = mem_req.reqtag;
				step();
				repeat (draw(MAX_WAIT)) step();
				mem_reqack = 1'b1; // One-cycle pulse.
				step();
				mem_reqack = 1'b0;
				for (int k = 0; k < `ARB_BURST_LEN; k++) begin
					repeat (draw(MAX_GAP)) step(); // Quiet cycles.
					mem_resp = '{respcyc: 1'b1, resp: word + k, resptag: tag};
					step();
					mem_resp = IDLE;
				end
				while (mem_respack) step(); // Arbiter closes the burst.
			end
		end
	end

endmodule

// File: verilog/arbiter_fsm.sv
// Grant FSM for two caches; icache always wins a tie and only one transfer runs at a time.
`timescale 1ns/100ps

module arbiter_fsm import arbiter_pkg::*; (
	input  logic   bus,           // Bus clock.
	input  logic   rst_n,         // Async, active low.
	input  logic   icache_reqcyc, // Instruction cache request strobe.
	input  logic   dcache_reqcyc, // Data cache request strobe.
	input  logic   burst_done,    // Full burst seen and bus quiet.
	output grant_t grant,         // Current owner.
	output logic   load,          // Capture the winner's request.
	output logic   clear          // Restart the beat count.
);

	grant_t grant_next;
	logic   idle;
	logic   any_req;

	// Idle is encoded as no owner, so grant is the whole state.
	assign idle    = (grant == grant_none);
	assign any_req = icache_reqcyc | dcache_reqcyc;

	// Accepting a request happens in the idle cycle the strobe is seen.
	// Leaving idle right away keeps both pulses to one cycle.
	assign load  = idle & any_req;
	assign clear = idle & any_req; // New transfer, new count.

	// Next owner.
	always_comb begin
		grant_next = grant; // Hold by default.
		case (grant)
			grant_none: begin
				if (icache_reqcyc) begin
					grant_next = grant_icache; // Instruction fetch first.
				end else if (dcache_reqcyc) begin
					grant_next = grant_dcache;
				end
			end
			grant_icache,
			grant_dcache: begin
				// Busy until the last beat has passed and respcyc dropped.
				if (burst_done) begin
					grant_next = grant_none;
				end
			end
			default: begin
				grant_next = grant_none; // Recover from an unused code.
			end
		endcase
	end

	// State register.
	always_ff @(posedge bus or negedge rst_n) begin
		if (!rst_n) begin
			grant <= grant_none;
		end else begin
			grant <= grant_next;
		end
	end

	// A waiting cache just holds reqcyc.
	// It is picked up on the first idle cycle after the current burst,
	// so the losing cache never needs to retry.
	// No queue of pending requests is kept here.
	// Fairness is not attempted: a steady icache stream can starve dcache.

endmodule

// File: verilog/arbiter_pkg.sv
// Shared arbiter types; all widths come from arbiter_defs.svh and cannot be overridden per instance.
package arbiter_pkg;

`include "arbiter_defs.svh"

	// Request from a cache toward the arbiter.
	typedef struct packed {
		logic                   reqcyc; // Held until reqack.
		logic [`ARB_DATA_W-1:0] req;    // Request word.
		logic [`ARB_TAG_W-1:0]  reqtag; // Tag echoed by memory.
	} cache_req_t;

	// Same layout, driven by the arbiter onto the system bus.
	typedef struct packed {
		logic                   reqcyc; // Dropped after mem_reqack.
		logic [`ARB_DATA_W-1:0] req;
		logic [`ARB_TAG_W-1:0]  reqtag;
	} bus_req_t;

	// One beat from the system bus.
	typedef struct packed {
		logic                   respcyc; // High for one beat.
		logic [`ARB_DATA_W-1:0] resp;
		logic [`ARB_TAG_W-1:0]  resptag;
	} bus_resp_t;

	// One beat as delivered to a cache.
	typedef struct packed {
		logic                   respcyc; // Held over the whole burst.
		logic [`ARB_DATA_W-1:0] resp;    // All ones when no beat.
		logic [`ARB_TAG_W-1:0]  resptag;
	} cache_resp_t;

	// Current bus owner; grant_none doubles as the idle state.
	typedef enum logic [1:0] {
		grant_none   = 2'd0,
		grant_icache = 2'd1,
		grant_dcache = 2'd2
	} grant_t;

	// Beat count, wide enough to hold the full burst length.
	typedef logic [$clog2(`ARB_BURST_LEN + 1)-1:0] beat_count_t;

endpackage

// File: verilog/beat_counter.sv
// Response beat counter; assumes exactly ARB_BURST_LEN beats per burst and saturates there.
`timescale 1ns/100ps

`include "arbiter_defs.svh"

module beat_counter import arbiter_pkg::*; (
	input  logic        bus,        // Bus clock.
	input  logic        rst_n,      // Async, active low.
	input  logic        clear,      // One-cycle pulse on grant.
	input  logic        respcyc,    // Beat valid from the bus.
	output beat_count_t beat_count, // Beats since last clear.
	output logic        burst_done  // Full count and bus quiet.
);

	localparam beat_count_t FULL = beat_count_t'(`ARB_BURST_LEN);

	// Beats since the last grant.
	always_ff @(posedge bus or negedge rst_n) begin
		if (!rst_n) begin
			beat_count <= '0;
		end else if (clear) begin
			beat_count <= '0; // Fresh transfer.
		end else if (respcyc && (beat_count != FULL)) begin
			beat_count <= beat_count + 1'b1; // Stop at full.
		end
	end

	// The burst is over once every beat has arrived and the bus has
	// lowered respcyc again, as the bus may hold the strobe past the
	// last beat for a cycle.
	// Stays high while idle; the FSM and router ignore it then.
	assign burst_done = (beat_count == FULL) & ~respcyc;

endmodule

// File: verilog/mem_arbiter.sv
// Two-cache memory arbiter top; one transfer in flight, icache priority, fixed eight-beat read bursts.
`timescale 1ns/100ps

module mem_arbiter import arbiter_pkg::*; (
	input  logic        bus,           // Bus clock.
	input  logic        rst_n,         // Async, active low.
	input  cache_req_t  icache_req,    // From the instruction cache.
	input  cache_req_t  dcache_req,    // From the data cache.
	input  logic        mem_reqack,    // One-cycle pulse from memory.
	input  bus_resp_t   mem_resp,      // Response beats.
	output logic        icache_reqack,
	output logic        dcache_reqack,
	output cache_resp_t icache_resp,
	output cache_resp_t dcache_resp,
	output bus_req_t    mem_req,       // Request toward memory.
	output logic        mem_respack    // Held over the burst.
);

	grant_t grant;      // Current owner.
	logic   load;       // Capture pulse.
	logic   clear;      // Count restart pulse.
	logic   burst_done; // End of transfer.

	// Owner selection.
	arbiter_fsm u_fsm (
		.bus           (bus),
		.rst_n         (rst_n),
		.icache_reqcyc (icache_req.reqcyc),
		.dcache_reqcyc (dcache_req.reqcyc),
		.burst_done    (burst_done),
		.grant         (grant),
		.load          (load),
		.clear         (clear)
	);

	// Count is only needed internally for burst_done.
	beat_counter u_beats (
		.bus        (bus),
		.rst_n      (rst_n),
		.clear      (clear),
		.respcyc    (mem_resp.respcyc),
		.beat_count (),
		.burst_done (burst_done)
	);

	request_mux u_req (
		.bus           (bus),
		.rst_n         (rst_n),
		.icache_req    (icache_req),
		.dcache_req    (dcache_req),
		.grant         (grant),
		.load          (load),
		.mem_reqack    (mem_reqack),
		.mem_req       (mem_req),
		.icache_reqack (icache_reqack),
		.dcache_reqack (dcache_reqack)
	);

	response_router u_resp (
		.bus         (bus),
		.rst_n       (rst_n),
		.grant       (grant),
		.mem_resp    (mem_resp),
		.burst_done  (burst_done),
		.icache_resp (icache_resp),
		.dcache_resp (dcache_resp),
		.mem_respack (mem_respack)
	);

endmodule

// File: verilog/request_mux.sv
// Bus request path; captured only on load, and the caches hold theirs until reqack.
`timescale 1ns/100ps

module request_mux import arbiter_pkg::*; (
	input  logic       bus,           // Bus clock.
	input  logic       rst_n,         // Async, active low.
	input  cache_req_t icache_req,    // Instruction cache request.
	input  cache_req_t dcache_req,    // Data cache request.
	input  grant_t     grant,         // Owner, valid from the load edge.
	input  logic       load,          // Capture this cycle.
	input  logic       mem_reqack,    // Bus took the request.
	output bus_req_t   mem_req,       // Request toward memory.
	output logic       icache_reqack, // One-cycle acknowledge.
	output logic       dcache_reqack  // One-cycle acknowledge.
);

	cache_req_t winner;

	logic                   reqcyc_q;
	logic [$bits(winner.req)-1:0]    req_q;
	logic [$bits(winner.reqtag)-1:0] reqtag_q;
	logic                   loaded_q; // High the cycle after load.
	logic                   reqack_q; // Bus ack sampled at the last edge.

	// Same priority as the FSM, so the word follows the new grant.
	assign winner = icache_req.reqcyc ? icache_req : dcache_req;

	// Request strobe toward the bus.
	always_ff @(posedge bus or negedge rst_n) begin
		if (!rst_n) begin
			reqcyc_q <= 1'b0;
		end else if (load) begin
			reqcyc_q <= 1'b1;
		end else if (reqack_q) begin
			reqcyc_q <= 1'b0; // One edge after the ack was sampled.
		end
	end

	// Word and tag only change on a new grant.
	always_ff @(posedge bus) begin
		if (load) begin
			req_q    <= winner.req;
			reqtag_q <= winner.reqtag;
		end
	end

	// Marks the first cycle of a transfer and delays the bus ack.
	always_ff @(posedge bus or negedge rst_n) begin
		if (!rst_n) begin
			loaded_q <= 1'b0;
			reqack_q <= 1'b0;
		end else begin
			loaded_q <= load;
			reqack_q <= mem_reqack;
		end
	end

	assign mem_req = '{reqcyc: reqcyc_q, req: req_q, reqtag: reqtag_q};

	// The ack goes to whoever grant now names.
	// It lines up with the rise of mem_req.reqcyc.
	assign icache_reqack = loaded_q & (grant == grant_icache);
	assign dcache_reqack = loaded_q & (grant == grant_dcache);

endmodule

// File: verilog/response_router.sv
// Response steering to the owning cache; beats are never back-pressured and must be taken the cycle they land.
`timescale 1ns/100ps

module response_router import arbiter_pkg::*; (
	input  logic        bus,         // Bus clock.
	input  logic        rst_n,       // Async, active low.
	input  grant_t      grant,       // Current owner.
	input  bus_resp_t   mem_resp,    // Beat from memory.
	input  logic        burst_done,  // Ends the transfer.
	output cache_resp_t icache_resp, // Beats for the icache.
	output cache_resp_t dcache_resp, // Beats for the dcache.
	output logic        mem_respack  // Level over the burst.
);

	logic busy;

	assign busy = (grant != grant_none);

	// Next value for one cache's response register.
	// A beat is copied through; a gap shows all ones on resp but keeps
	// respcyc until the burst ends, like the bus side does.
	function automatic cache_resp_t route_beat(
		input cache_resp_t cur,
		input logic        mine,
		input bus_resp_t   beat,
		input logic        done
	);
		cache_resp_t nxt;
		nxt      = cur;
		nxt.resp = '1; // Idle data path.
		if (mine && beat.respcyc) begin
			nxt.respcyc = 1'b1;
			nxt.resp    = beat.resp;
			nxt.resptag = beat.resptag;
		end else if (!mine || done) begin
			nxt.respcyc = 1'b0; // Not ours, or burst over.
		end
		return nxt;
	endfunction

	// One register per cache, same rule for both.
	always_ff @(posedge bus or negedge rst_n) begin
		if (!rst_n) begin
			icache_resp <= '{respcyc: 1'b0, resp: '1, resptag: '0};
			dcache_resp <= '{respcyc: 1'b0, resp: '1, resptag: '0};
		end else begin
			icache_resp <= route_beat(icache_resp, grant == grant_icache, mem_resp, burst_done);
			dcache_resp <= route_beat(dcache_resp, grant == grant_dcache, mem_resp, burst_done);
		end
	end

	// Acknowledge level toward memory.
	always_ff @(posedge bus or negedge rst_n) begin
		if (!rst_n) begin
			mem_respack <= 1'b0;
		end else if (busy && mem_resp.respcyc) begin
			mem_respack <= 1'b1; // Rises with the first delivered beat.
		end else if (busy && burst_done) begin
			mem_respack <= 1'b0; // Falls with the owner's respcyc.
		end
	end

endmodule
